//--- Bender.yml
package:
  name: axil_bridge

sources:
  - files:
      - axil_bridge_pkg.sv
      - mem_fwd_dispatch.sv
      - axil_write_engine.sv
      - axil_read_engine.sv
      - mem_rev_packer.sv
      - axil_master_top.sv
  - target: test
    files:
      - tb_axil_slave_model.sv
      - tb_axil_master.sv

//--- axil_bridge_pkg.sv
`default_nettype none

package axil_bridge_pkg;

  // Bus widths fixed by the stream format
  localparam int data_width_lp   = 64;
  localparam int addr_width_lp   = 32;
  localparam int strb_width_lp   = data_width_lp / 8;
  localparam int offset_width_lp = $clog2(strb_width_lp);
  localparam int resp_width_lp   = 2;
  localparam int prot_width_lp   = 3;
  localparam int tag_width_lp    = 8;

  // AXI response code for a successful transfer
  localparam logic [resp_width_lp-1:0] axil_resp_okay_lp = 2'b00;

  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } msg_type_e;

  // Byte count is 2**size
  typedef enum logic [1:0]
  {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } msg_size_e;

  // Err is only meaningful on the reverse stream
  typedef struct packed
  {
    msg_type_e                msg_type;
    msg_size_e                size;
    logic [tag_width_lp-1:0]  tag;
    logic [addr_width_lp-1:0] addr;
    logic                     err;
  } mem_hdr_s;

  typedef struct packed
  {
    logic [addr_width_lp-1:0] awaddr;
    logic [prot_width_lp-1:0] awprot;
  } axil_aw_s;

  typedef struct packed
  {
    logic [data_width_lp-1:0] wdata;
    logic [strb_width_lp-1:0] wstrb;
  } axil_w_s;

  typedef struct packed
  {
    logic [addr_width_lp-1:0] araddr;
    logic [prot_width_lp-1:0] arprot;
  } axil_ar_s;

  typedef struct packed
  {
    logic [data_width_lp-1:0] rdata;
    logic [resp_width_lp-1:0] rresp;
  } axil_r_s;

endpackage

`default_nettype wire

//--- axil_master_top.sv
`timescale 1ns/100ps
`default_nettype none

module axil_master_top
  (
    input  wire                                        clk_i,
    input  wire                                        rst_n_i,

    // Forward stream
    input  axil_bridge_pkg::mem_hdr_s                  mem_fwd_header_i,
    input  wire [axil_bridge_pkg::data_width_lp-1:0]   mem_fwd_data_i,
    input  wire                                        mem_fwd_v_i,
    output logic                                       mem_fwd_ready_and_o,

    // Reverse stream
    output axil_bridge_pkg::mem_hdr_s                  mem_rev_header_o,
    output logic [axil_bridge_pkg::data_width_lp-1:0]  mem_rev_data_o,
    output logic                                       mem_rev_v_o,
    input  wire                                        mem_rev_ready_and_i,

    // AXI4-Lite master
    output axil_bridge_pkg::axil_aw_s                  m_axil_aw_o,
    output logic                                       m_axil_awvalid_o,
    input  wire                                        m_axil_awready_i,
    output axil_bridge_pkg::axil_w_s                   m_axil_w_o,
    output logic                                       m_axil_wvalid_o,
    input  wire                                        m_axil_wready_i,
    input  wire [axil_bridge_pkg::resp_width_lp-1:0]   m_axil_bresp_i,
    input  wire                                        m_axil_bvalid_i,
    output logic                                       m_axil_bready_o,
    output axil_bridge_pkg::axil_ar_s                  m_axil_ar_o,
    output logic                                       m_axil_arvalid_o,
    input  wire                                        m_axil_arready_i,
    input  wire [axil_bridge_pkg::data_width_lp-1:0]   m_axil_rdata_i,
    input  wire [axil_bridge_pkg::resp_width_lp-1:0]   m_axil_rresp_i,
    input  wire                                        m_axil_rvalid_i,
    output logic                                       m_axil_rready_o
  );

  logic                       wr_start;
  logic                       rd_start;
  logic                       wr_done;
  logic                       wr_err;
  logic                       rd_done;
  logic                       rev_done;
  axil_bridge_pkg::axil_aw_s  aw;
  axil_bridge_pkg::axil_w_s   w;
  axil_bridge_pkg::axil_ar_s  ar;
  axil_bridge_pkg::axil_r_s   r;
  axil_bridge_pkg::mem_hdr_s  req_hdr;

  mem_fwd_dispatch dispatch0
  (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .mem_fwd_header_i    (mem_fwd_header_i),
    .mem_fwd_data_i      (mem_fwd_data_i),
    .mem_fwd_v_i         (mem_fwd_v_i),
    .mem_fwd_ready_and_o (mem_fwd_ready_and_o),
    .rev_done_i          (rev_done),
    .wr_start_o          (wr_start),
    .aw_o                (aw),
    .w_o                 (w),
    .rd_start_o          (rd_start),
    .ar_o                (ar),
    .req_hdr_o           (req_hdr)
  );

  axil_write_engine wr0
  (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .wr_start_i       (wr_start),
    .aw_i             (aw),
    .w_i              (w),
    .m_axil_aw_o      (m_axil_aw_o),
    .m_axil_awvalid_o (m_axil_awvalid_o),
    .m_axil_awready_i (m_axil_awready_i),
    .m_axil_w_o       (m_axil_w_o),
    .m_axil_wvalid_o  (m_axil_wvalid_o),
    .m_axil_wready_i  (m_axil_wready_i),
    .m_axil_bresp_i   (m_axil_bresp_i),
    .m_axil_bvalid_i  (m_axil_bvalid_i),
    .m_axil_bready_o  (m_axil_bready_o),
    .wr_done_o        (wr_done),
    .wr_err_o         (wr_err)
  );

  axil_read_engine rd0
  (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .rd_start_i       (rd_start),
    .ar_i             (ar),
    .m_axil_ar_o      (m_axil_ar_o),
    .m_axil_arvalid_o (m_axil_arvalid_o),
    .m_axil_arready_i (m_axil_arready_i),
    .m_axil_rdata_i   (m_axil_rdata_i),
    .m_axil_rresp_i   (m_axil_rresp_i),
    .m_axil_rvalid_i  (m_axil_rvalid_i),
    .m_axil_rready_o  (m_axil_rready_o),
    .rd_done_o        (rd_done),
    .r_o              (r)
  );

  mem_rev_packer pack0
  (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .req_hdr_i           (req_hdr),
    .wr_done_i           (wr_done),
    .wr_err_i            (wr_err),
    .rd_done_i           (rd_done),
    .r_i                 (r),
    .mem_rev_header_o    (mem_rev_header_o),
    .mem_rev_data_o      (mem_rev_data_o),
    .mem_rev_v_o         (mem_rev_v_o),
    .mem_rev_ready_and_i (mem_rev_ready_and_i),
    .rev_done_o          (rev_done)
  );

endmodule

`default_nettype wire

//--- axil_read_engine.sv
`timescale 1ns/100ps
`default_nettype none

module axil_read_engine
  (
    input  wire                                        clk_i,
    input  wire                                        rst_n_i,
    input  wire                                        rd_start_i,
    input  axil_bridge_pkg::axil_ar_s                  ar_i,
    output axil_bridge_pkg::axil_ar_s                  m_axil_ar_o,
    output logic                                       m_axil_arvalid_o,
    input  wire                                        m_axil_arready_i,
    input  wire [axil_bridge_pkg::data_width_lp-1:0]   m_axil_rdata_i,
    input  wire [axil_bridge_pkg::resp_width_lp-1:0]   m_axil_rresp_i,
    input  wire                                        m_axil_rvalid_i,
    output logic                                       m_axil_rready_o,
    output logic                                       rd_done_o,
    output axil_bridge_pkg::axil_r_s                   r_o
  );

  logic ar_fire;
  logic r_fire;

  assign ar_fire = m_axil_arvalid_o & m_axil_arready_i;
  assign r_fire  = m_axil_rvalid_i & m_axil_rready_o;

  // Address phase is ARVALID, data phase is RREADY
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      m_axil_arvalid_o <= 1'b0;
      m_axil_rready_o  <= 1'b0;
      rd_done_o        <= 1'b0;
    end
    else
    begin
      rd_done_o <= r_fire;

      if (rd_start_i)
        m_axil_arvalid_o <= 1'b1;
      else if (ar_fire)
        m_axil_arvalid_o <= 1'b0;

      if (ar_fire)
        m_axil_rready_o <= 1'b1;
      else if (r_fire)
        m_axil_rready_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_start_i)
      m_axil_ar_o <= ar_i;
  end

  // Captured R beat, valid alongside rd_done
  always_ff @(posedge clk_i)
  begin
    if (r_fire)
    begin
      r_o.rdata <= m_axil_rdata_i;
      r_o.rresp <= m_axil_rresp_i;
    end
  end

endmodule

`default_nettype wire

//--- axil_write_engine.sv
`timescale 1ns/100ps
`default_nettype none

module axil_write_engine
  (
    input  wire                                        clk_i,
    input  wire                                        rst_n_i,
    input  wire                                        wr_start_i,
    input  axil_bridge_pkg::axil_aw_s                  aw_i,
    input  axil_bridge_pkg::axil_w_s                   w_i,
    output axil_bridge_pkg::axil_aw_s                  m_axil_aw_o,
    output logic                                       m_axil_awvalid_o,
    input  wire                                        m_axil_awready_i,
    output axil_bridge_pkg::axil_w_s                   m_axil_w_o,
    output logic                                       m_axil_wvalid_o,
    input  wire                                        m_axil_wready_i,
    input  wire [axil_bridge_pkg::resp_width_lp-1:0]   m_axil_bresp_i,
    input  wire                                        m_axil_bvalid_i,
    output logic                                       m_axil_bready_o,
    output logic                                       wr_done_o,
    output logic                                       wr_err_o
  );

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic aw_clear;
  logic w_clear;
  logic addr_phase;

  assign aw_fire = m_axil_awvalid_o & m_axil_awready_i;
  assign w_fire  = m_axil_wvalid_o & m_axil_wready_i;
  assign b_fire  = m_axil_bvalid_i & m_axil_bready_o;

  // AW and W may complete in either order
  assign aw_clear   = ~m_axil_awvalid_o | m_axil_awready_i;
  assign w_clear    = ~m_axil_wvalid_o | m_axil_wready_i;
  assign addr_phase = m_axil_awvalid_o | m_axil_wvalid_o;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      m_axil_awvalid_o <= 1'b0;
      m_axil_wvalid_o  <= 1'b0;
      m_axil_bready_o  <= 1'b0;
      wr_done_o        <= 1'b0;
      wr_err_o         <= 1'b0;
    end
    else
    begin
      wr_done_o <= b_fire;

      if (wr_start_i)
      begin
        m_axil_awvalid_o <= 1'b1;
        m_axil_wvalid_o  <= 1'b1;
      end
      else
      begin
        if (aw_fire)
          m_axil_awvalid_o <= 1'b0;
        if (w_fire)
          m_axil_wvalid_o <= 1'b0;
      end

      // Response phase opens once both channels are done
      if (addr_phase & aw_clear & w_clear)
        m_axil_bready_o <= 1'b1;
      else if (b_fire)
        m_axil_bready_o <= 1'b0;

      if (b_fire)
        wr_err_o <= (m_axil_bresp_i != axil_bridge_pkg::axil_resp_okay_lp);
    end
  end

  // Channel payloads stay stable while valid is up
  always_ff @(posedge clk_i)
  begin
    if (wr_start_i)
    begin
      m_axil_aw_o <= aw_i;
      m_axil_w_o  <= w_i;
    end
  end

endmodule

`default_nettype wire

//--- mem_fwd_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module mem_fwd_dispatch
  (
    input  wire                                        clk_i,
    input  wire                                        rst_n_i,
    input  axil_bridge_pkg::mem_hdr_s                  mem_fwd_header_i,
    input  wire [axil_bridge_pkg::data_width_lp-1:0]   mem_fwd_data_i,
    input  wire                                        mem_fwd_v_i,
    output logic                                       mem_fwd_ready_and_o,
    input  wire                                        rev_done_i,
    output logic                                       wr_start_o,
    output axil_bridge_pkg::axil_aw_s                  aw_o,
    output axil_bridge_pkg::axil_w_s                   w_o,
    output logic                                       rd_start_o,
    output axil_bridge_pkg::axil_ar_s                  ar_o,
    output axil_bridge_pkg::mem_hdr_s                  req_hdr_o
  );

  logic                                          busy_r;
  logic                                          fwd_fire;
  logic [axil_bridge_pkg::offset_width_lp-1:0]   lane_offset;
  logic [axil_bridge_pkg::strb_width_lp-1:0]     strb_n;

  // Single request slot
  assign mem_fwd_ready_and_o = ~busy_r;
  assign fwd_fire            = mem_fwd_v_i & ~busy_r;

  // Offset rounded down to the access size
  always_comb
  begin
    lane_offset = mem_fwd_header_i.addr[axil_bridge_pkg::offset_width_lp-1:0]
                & (3'b111 << mem_fwd_header_i.size);
    case (mem_fwd_header_i.size)
      axil_bridge_pkg::e_size_1: strb_n = 8'h01 << lane_offset;
      axil_bridge_pkg::e_size_2: strb_n = 8'h03 << lane_offset;
      axil_bridge_pkg::e_size_4: strb_n = 8'h0f << lane_offset;
      default:                   strb_n = {axil_bridge_pkg::strb_width_lp{1'b1}};
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      busy_r     <= 1'b0;
      wr_start_o <= 1'b0;
      rd_start_o <= 1'b0;
    end
    else
    begin
      wr_start_o <= fwd_fire & (mem_fwd_header_i.msg_type == axil_bridge_pkg::e_mem_wr);
      rd_start_o <= fwd_fire & (mem_fwd_header_i.msg_type == axil_bridge_pkg::e_mem_rd);
      if (fwd_fire)
        busy_r <= 1'b1;
      else if (rev_done_i)
        busy_r <= 1'b0;
    end
  end

  // Request payload, held for the whole transaction
  always_ff @(posedge clk_i)
  begin
    if (fwd_fire)
    begin
      req_hdr_o     <= mem_fwd_header_i;
      aw_o.awaddr   <= mem_fwd_header_i.addr;
      aw_o.awprot   <= '0;
      w_o.wdata     <= mem_fwd_data_i;
      w_o.wstrb     <= strb_n;
      ar_o.araddr   <= mem_fwd_header_i.addr;
      ar_o.arprot   <= '0;
    end
  end

endmodule

`default_nettype wire

//--- mem_rev_packer.sv
`timescale 1ns/100ps
`default_nettype none

module mem_rev_packer
  (
    input  wire                                        clk_i,
    input  wire                                        rst_n_i,
    input  axil_bridge_pkg::mem_hdr_s                  req_hdr_i,
    input  wire                                        wr_done_i,
    input  wire                                        wr_err_i,
    input  wire                                        rd_done_i,
    input  axil_bridge_pkg::axil_r_s                   r_i,
    output axil_bridge_pkg::mem_hdr_s                  mem_rev_header_o,
    output logic [axil_bridge_pkg::data_width_lp-1:0]  mem_rev_data_o,
    output logic                                       mem_rev_v_o,
    input  wire                                        mem_rev_ready_and_i,
    output logic                                       rev_done_o
  );

  logic [axil_bridge_pkg::offset_width_lp-1:0] lane_sel;
  logic [axil_bridge_pkg::data_width_lp-1:0]   shifted;
  logic [axil_bridge_pkg::data_width_lp-1:0]   packed_data;
  logic                                        rd_err;

  assign rev_done_o = mem_rev_v_o & mem_rev_ready_and_i;
  assign rd_err     = (r_i.rresp != axil_bridge_pkg::axil_resp_okay_lp);

  // Narrow read field moved to lane 0, then copied across the word
  always_comb
  begin
    lane_sel = req_hdr_i.addr[axil_bridge_pkg::offset_width_lp-1:0]
             & (3'b111 << req_hdr_i.size);
    shifted  = r_i.rdata >> {lane_sel, 3'b000};
    case (req_hdr_i.size)
      axil_bridge_pkg::e_size_1: packed_data = {8{shifted[7:0]}};
      axil_bridge_pkg::e_size_2: packed_data = {4{shifted[15:0]}};
      axil_bridge_pkg::e_size_4: packed_data = {2{shifted[31:0]}};
      default:                   packed_data = r_i.rdata;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      mem_rev_v_o <= 1'b0;
    else if (wr_done_i | rd_done_i)
      mem_rev_v_o <= 1'b1;
    else if (rev_done_o)
      mem_rev_v_o <= 1'b0;
  end

  // Reverse payload, stable until accepted
  always_ff @(posedge clk_i)
  begin
    if (wr_done_i)
    begin
      mem_rev_header_o     <= req_hdr_i;
      mem_rev_header_o.err <= wr_err_i;
      mem_rev_data_o       <= '0;
    end
    else if (rd_done_i)
    begin
      mem_rev_header_o     <= req_hdr_i;
      mem_rev_header_o.err <= rd_err;
      mem_rev_data_o       <= packed_data;
    end
  end

endmodule

`default_nettype wire

//--- sim.f
axil_bridge_pkg.sv
mem_fwd_dispatch.sv
axil_write_engine.sv
axil_read_engine.sv
mem_rev_packer.sv
axil_master_top.sv
tb_axil_slave_model.sv
tb_axil_master.sv

//--- tb_axil_master.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axil_master;

  localparam int err_first_lp = 240;
  localparam int timeout_lp   = 200;

  logic                       clk;
  logic                       rst_n;
  axil_bridge_pkg::mem_hdr_s  fwd_hdr;
  logic [63:0]                fwd_data;
  logic                       fwd_v;
  logic                       fwd_ready;
  axil_bridge_pkg::mem_hdr_s  rev_hdr;
  logic [63:0]                rev_data;
  logic                       rev_v;
  logic                       rev_ready;
  axil_bridge_pkg::axil_aw_s  aw;
  axil_bridge_pkg::axil_w_s   w;
  axil_bridge_pkg::axil_ar_s  ar;
  logic                       awvalid;
  logic                       awready;
  logic                       wvalid;
  logic                       wready;
  logic [1:0]                 bresp;
  logic                       bvalid;
  logic                       bready;
  logic                       arvalid;
  logic                       arready;
  logic [63:0]                rdata;
  logic [1:0]                 rresp;
  logic                       rvalid;
  logic                       rready;

  logic [63:0] shadow [0:255];
  logic [7:0]  touched [$];
  string       cur_test;
  int          err_cnt;
  int          test_err;
  int          test_cnt;
  int          test_fail;
  bit          rev_stall;
  bit          hung;

  always #5 clk = ~clk;

  axil_master_top dut0
  (
    .clk_i (clk), .rst_n_i (rst_n),
    .mem_fwd_header_i (fwd_hdr), .mem_fwd_data_i (fwd_data),
    .mem_fwd_v_i (fwd_v), .mem_fwd_ready_and_o (fwd_ready),
    .mem_rev_header_o (rev_hdr), .mem_rev_data_o (rev_data),
    .mem_rev_v_o (rev_v), .mem_rev_ready_and_i (rev_ready),
    .m_axil_aw_o (aw), .m_axil_awvalid_o (awvalid), .m_axil_awready_i (awready),
    .m_axil_w_o (w), .m_axil_wvalid_o (wvalid), .m_axil_wready_i (wready),
    .m_axil_bresp_i (bresp), .m_axil_bvalid_i (bvalid), .m_axil_bready_o (bready),
    .m_axil_ar_o (ar), .m_axil_arvalid_o (arvalid), .m_axil_arready_i (arready),
    .m_axil_rdata_i (rdata), .m_axil_rresp_i (rresp),
    .m_axil_rvalid_i (rvalid), .m_axil_rready_o (rready)
  );

  tb_axil_slave_model slave0
  (
    .clk_i (clk), .rst_n_i (rst_n),
    .s_axil_aw_i (aw), .s_axil_awvalid_i (awvalid), .s_axil_awready_o (awready),
    .s_axil_w_i (w), .s_axil_wvalid_i (wvalid), .s_axil_wready_o (wready),
    .s_axil_bresp_o (bresp), .s_axil_bvalid_o (bvalid), .s_axil_bready_i (bready),
    .s_axil_ar_i (ar), .s_axil_arvalid_i (arvalid), .s_axil_arready_o (arready),
    .s_axil_rdata_o (rdata), .s_axil_rresp_o (rresp),
    .s_axil_rvalid_o (rvalid), .s_axil_rready_i (rready)
  );

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act)
    begin
      $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error in %s: %s", cur_test, msg);
    err_cnt++;
    test_err++;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_err = 0;
    test_cnt++;
  endtask

  task automatic end_test();
    if (test_err == 0)
      $display("test %s: ok", cur_test);
    else
    begin
      $display("test %s: %0d errors", cur_test, test_err);
      test_fail++;
    end
  endtask

  function automatic logic [7:0] pick_idx(input bit in_err);
    int unsigned r;
    r = $urandom;
    if (in_err)
      pick_idx = 8'(err_first_lp + r % (256 - err_first_lp));
    else
      pick_idx = 8'(r % err_first_lp);
  endfunction

  // Entered and left on a falling edge
  task automatic send_fwd(input axil_bridge_pkg::mem_hdr_s hdr, input logic [63:0] data,
                          output bit ok);
    int waited;
    waited = 0;
    while (!fwd_ready && waited < timeout_lp)
    begin
      @(negedge clk);
      waited++;
    end
    ok = fwd_ready;
    if (!ok)
      report_error("forward ready did not return within the timeout");
    else
    begin
      fwd_hdr  = hdr;
      fwd_data = data;
      fwd_v    = 1'b1;
      @(negedge clk);
      fwd_v = 1'b0;
    end
  endtask

  task automatic recv_rev(output axil_bridge_pkg::mem_hdr_s hdr, output logic [63:0] data,
                          output bit ok);
    int waited;
    waited = 0;
    ok     = 1'b0;
    while (!ok && waited < timeout_lp)
    begin
      if (fwd_ready)
        report_error("forward ready high while a request is outstanding");
      // AxPROT is always zero on this bridge
      if (awvalid)
        check_value("awprot", 0, aw.awprot);
      if (arvalid)
        check_value("arprot", 0, ar.arprot);
      rev_ready = rev_stall ? ($urandom % 3 != 0) : 1'b1;
      // Handshake happens at the coming rising edge
      if (rev_v && rev_ready)
      begin
        hdr  = rev_hdr;
        data = rev_data;
        ok   = 1'b1;
      end
      @(negedge clk);
      waited++;
    end
    rev_ready = 1'b0;
    if (!ok)
      report_error("no reverse message within the timeout");
  endtask

  // One request through the bridge checked against the shadow memory
  task automatic do_access(input axil_bridge_pkg::msg_type_e kind,
                           input axil_bridge_pkg::msg_size_e size,
                           input logic [7:0] idx, input logic [2:0] off,
                           input logic [63:0] wdata);
    axil_bridge_pkg::mem_hdr_s req;
    axil_bridge_pkg::mem_hdr_s exp_hdr;
    axil_bridge_pkg::mem_hdr_s got_hdr;
    logic [63:0]               exp_data;
    logic [63:0]               got_data;
    logic [63:0]               field;
    logic [31:0]               r;
    int                        nbytes;
    int                        aoff;
    int                        b;
    bit                        ok;
    if (hung)
      return;
    r            = $urandom;
    nbytes       = 1 << size;
    aoff         = (off / nbytes) * nbytes;
    req          = '0;
    req.msg_type = kind;
    req.size     = size;
    req.tag      = r[7:0];
    req.addr     = {21'd0, idx, off};
    exp_hdr      = req;
    exp_hdr.err  = (idx >= err_first_lp);
    exp_data     = '0;
    if (kind == axil_bridge_pkg::e_mem_wr && !exp_hdr.err)
    begin
      for (b = aoff; b < aoff + nbytes; b++)
        shadow[idx][8*b +: 8] = wdata[8*b +: 8];
    end
    else if (kind == axil_bridge_pkg::e_mem_rd && !exp_hdr.err)
    begin
      field = shadow[idx] >> (8 * aoff);
      for (b = 0; b < 8; b++)
        exp_data[8*b +: 8] = field[8*(b % nbytes) +: 8];
    end
    send_fwd(req, wdata, ok);
    if (ok)
      recv_rev(got_hdr, got_data, ok);
    if (!ok)
    begin
      hung = 1'b1;
      return;
    end
    check_value("header", 64'(exp_hdr), 64'(got_hdr));
    check_value("data", exp_data, got_data);
  endtask

  initial
  begin
    int unsigned               seed;
    int                        n;
    logic [7:0]                idx;
    logic [2:0]                off;
    axil_bridge_pkg::msg_size_e size;
    logic [31:0]               i32;
    seed      = $urandom(32'ha7a3_93d3);
    clk       = 1'b0;
    rst_n     = 1'b0;
    fwd_hdr   = '0;
    fwd_data  = '0;
    fwd_v     = 1'b0;
    rev_ready = 1'b0;
    err_cnt   = 0;
    test_cnt  = 0;
    test_fail = 0;
    rev_stall = 1'b0;
    hung      = 1'b0;
    for (n = 0; n < 256; n++)
    begin
      i32       = n;
      shadow[n] = {i32 * 32'h9e37_79b9, ~i32};
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    begin_test("reset_state");
    check_value("awvalid", 0, awvalid);
    check_value("wvalid", 0, wvalid);
    check_value("arvalid", 0, arvalid);
    check_value("bready", 0, bready);
    check_value("rready", 0, rready);
    check_value("rev_v", 0, rev_v);
    check_value("fwd_ready", 1, fwd_ready);
    end_test();

    begin_test("full_word");
    for (n = 0; n < 16; n++)
    begin
      idx = pick_idx(1'b0);
      touched.push_back(idx);
      do_access(axil_bridge_pkg::e_mem_wr, axil_bridge_pkg::e_size_8, idx, 3'd0,
                {$urandom, $urandom});
    end
    while (touched.size() > 0)
      do_access(axil_bridge_pkg::e_mem_rd, axil_bridge_pkg::e_size_8, touched.pop_front(),
                3'd0, '0);
    end_test();

    begin_test("sized_write");
    for (n = 0; n < 24; n++)
    begin
      idx  = pick_idx(1'b0);
      size = axil_bridge_pkg::msg_size_e'($urandom % 3);
      off  = 3'((($urandom % 8) >> size) << size);
      touched.push_back(idx);
      do_access(axil_bridge_pkg::e_mem_wr, size, idx, off, {$urandom, $urandom});
    end
    while (touched.size() > 0)
      do_access(axil_bridge_pkg::e_mem_rd, axil_bridge_pkg::e_size_8, touched.pop_front(),
                3'd0, '0);
    end_test();

    begin_test("sized_read");
    for (n = 0; n < 24; n++)
    begin
      size = axil_bridge_pkg::msg_size_e'($urandom % 3);
      off  = 3'((($urandom % 8) >> size) << size);
      do_access(axil_bridge_pkg::e_mem_rd, size, pick_idx(1'b0), off, '0);
    end
    end_test();

    begin_test("error_window");
    for (n = 0; n < 12; n++)
    begin
      size = axil_bridge_pkg::msg_size_e'($urandom % 4);
      do_access(n[0] ? axil_bridge_pkg::e_mem_wr : axil_bridge_pkg::e_mem_rd, size,
                pick_idx(1'b1), 3'd0, {$urandom, $urandom});
    end
    end_test();

    // Mixed traffic with reverse stream stalls
    begin_test("random_stall");
    rev_stall = 1'b1;
    for (n = 0; n < 60; n++)
    begin
      size = axil_bridge_pkg::msg_size_e'($urandom % 4);
      off  = 3'((($urandom % 8) >> size) << size);
      do_access(($urandom % 2) ? axil_bridge_pkg::e_mem_wr : axil_bridge_pkg::e_mem_rd,
                size, pick_idx($urandom % 8 == 0), off, {$urandom, $urandom});
    end
    rev_stall = 1'b0;
    end_test();

    $display("tests run %0d, tests failed %0d, check errors %0d",
             test_cnt, test_fail, err_cnt);
    if (err_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_axil_slave_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axil_slave_model
  (
    input  wire                                        clk_i,
    input  wire                                        rst_n_i,
    input  axil_bridge_pkg::axil_aw_s                  s_axil_aw_i,
    input  wire                                        s_axil_awvalid_i,
    output logic                                       s_axil_awready_o,
    input  axil_bridge_pkg::axil_w_s                   s_axil_w_i,
    input  wire                                        s_axil_wvalid_i,
    output logic                                       s_axil_wready_o,
    output logic [axil_bridge_pkg::resp_width_lp-1:0]  s_axil_bresp_o,
    output logic                                       s_axil_bvalid_o,
    input  wire                                        s_axil_bready_i,
    input  axil_bridge_pkg::axil_ar_s                  s_axil_ar_i,
    input  wire                                        s_axil_arvalid_i,
    output logic                                       s_axil_arready_o,
    output logic [axil_bridge_pkg::data_width_lp-1:0]  s_axil_rdata_o,
    output logic [axil_bridge_pkg::resp_width_lp-1:0]  s_axil_rresp_o,
    output logic                                       s_axil_rvalid_o,
    input  wire                                        s_axil_rready_i
  );

  // Top 16 words answer SLVERR
  localparam int         err_first_lp = 240;
  localparam logic [1:0] slverr_lp    = 2'b10;

  logic [axil_bridge_pkg::data_width_lp-1:0] mem [0:255];
  axil_bridge_pkg::axil_w_s                  w_q;
  logic [7:0]                                aw_idx;
  logic [7:0]                                ar_idx;
  logic                                      aw_pend;
  logic                                      w_pend;
  logic                                      ar_pend;
  logic                                      b_ack;
  logic                                      r_ack;
  logic [31:0]                               i32;
  int                                        i;
  int                                        b;

  // Fill depends on the whole word index
  initial
  begin
    for (i = 0; i < 256; i++)
    begin
      i32    = i;
      mem[i] = {i32 * 32'h9e37_79b9, ~i32};
    end
    s_axil_awready_o = 1'b0;
    s_axil_wready_o  = 1'b0;
    s_axil_bresp_o   = '0;
    s_axil_bvalid_o  = 1'b0;
    s_axil_arready_o = 1'b0;
    s_axil_rdata_o   = '0;
    s_axil_rresp_o   = '0;
    s_axil_rvalid_o  = 1'b0;
    aw_pend          = 1'b0;
    w_pend           = 1'b0;
    ar_pend          = 1'b0;
    b_ack            = 1'b0;
    r_ack            = 1'b0;
  end

  // Everything decided on the falling edge, the master's outputs are stable here
  always @(negedge clk_i)
  begin
    if (!rst_n_i)
    begin
      s_axil_awready_o = 1'b0;
      s_axil_wready_o  = 1'b0;
      s_axil_bvalid_o  = 1'b0;
      s_axil_arready_o = 1'b0;
      s_axil_rvalid_o  = 1'b0;
      aw_pend          = 1'b0;
      w_pend           = 1'b0;
      ar_pend          = 1'b0;
      b_ack            = 1'b0;
      r_ack            = 1'b0;
    end
    else
    begin
      // B and R beats taken at the last rising edge
      if (b_ack)
        s_axil_bvalid_o = 1'b0;
      if (r_ack)
        s_axil_rvalid_o = 1'b0;

      // Respond only to requests accepted at an earlier edge
      if (aw_pend && w_pend && !s_axil_bvalid_o && ($urandom % 3 == 0))
      begin
        if (aw_idx >= err_first_lp)
          s_axil_bresp_o = slverr_lp;
        else
        begin
          s_axil_bresp_o = axil_bridge_pkg::axil_resp_okay_lp;
          for (b = 0; b < 8; b++)
            if (w_q.wstrb[b])
              mem[aw_idx][8*b +: 8] = w_q.wdata[8*b +: 8];
        end
        s_axil_bvalid_o = 1'b1;
        aw_pend         = 1'b0;
        w_pend          = 1'b0;
      end
      if (ar_pend && !s_axil_rvalid_o && ($urandom % 3 == 0))
      begin
        s_axil_rdata_o  = (ar_idx >= err_first_lp) ? '0 : mem[ar_idx];
        s_axil_rresp_o  = (ar_idx >= err_first_lp) ? slverr_lp
                                                   : axil_bridge_pkg::axil_resp_okay_lp;
        s_axil_rvalid_o = 1'b1;
        ar_pend         = 1'b0;
      end

      // Random readies, so W may be taken before AW
      s_axil_awready_o = !aw_pend && ($urandom % 4 != 0);
      s_axil_wready_o  = !w_pend && ($urandom % 4 != 0);
      s_axil_arready_o = !ar_pend && !s_axil_rvalid_o && ($urandom % 4 != 0);
      if (s_axil_awready_o && s_axil_awvalid_i)
      begin
        aw_pend = 1'b1;
        aw_idx  = s_axil_aw_i.awaddr[10:3];
      end
      if (s_axil_wready_o && s_axil_wvalid_i)
      begin
        w_pend = 1'b1;
        w_q    = s_axil_w_i;
      end
      if (s_axil_arready_o && s_axil_arvalid_i)
      begin
        ar_pend = 1'b1;
        ar_idx  = s_axil_ar_i.araddr[10:3];
      end
      b_ack = s_axil_bvalid_o && s_axil_bready_i;
      r_ack = s_axil_rvalid_o && s_axil_rready_i;
    end
  end

endmodule

`default_nettype wire
